// File: flist.f
hdl/cache_pkg.sv
hdl/cache_way.sv
hdl/victim_select.sv
hdl/cache_2ways.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/tb_mem_model.sv
test/tb_cache_top.sv

// File: Bender.yml
package:
  name: cache_2way

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_way.sv
  - hdl/victim_select.sv
  - hdl/cache_2ways.sv
  - hdl/cache_ctrl.sv
  - hdl/cache_top.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_cache_top.sv

// File: test/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;
    import cache_pkg::*;

    //////////////////////////////////////////////////
    // run constants
    //////////////////////////////////////////////////

    localparam int    CLK_PERIOD = 20;
    localparam int    DRIVE_DELAY = 2;
    localparam int    RESET_CYCLES = 3;
    localparam int    MEM_WORDS_LOG2 = 10;
    localparam word_t FILL_XOR = 32'h5a3c_96e1;
    localparam int    DIRECTED_REQS = 13;
    localparam int    RANDOM_REQS = 300;
    // lookup, write-back and refill at two cycles a word, finish, ack and gap
    localparam int    MISS_BOUND = 32;
    // ack rises on the second edge, counting the one that samples stb as the first
    localparam int    HIT_ACK_EDGE = 2;
    localparam int    WATCHDOG_CYCLES =
        RESET_CYCLES + 8 + (DIRECTED_REQS + RANDOM_REQS) * MISS_BOUND;

    // clock and reset
    logic clk;
    logic rst_n;

    // processor port
    logic  cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    addr_t cpu_adr;
    be_t   cpu_sel;
    word_t cpu_dat_w, cpu_dat_r;

    // memory port
    logic  mem_cyc, mem_stb, mem_we, mem_ack;
    addr_t mem_adr;
    be_t   mem_sel;
    word_t mem_dat_w, mem_dat_r;

    // reference memory image
    word_t shadow [1 << MEM_WORDS_LOG2];

    // what the comparing process expects on the next ack
    string chk_name;
    logic  chk_read;
    word_t exp_data;
    int    reads_issued;
    int    reads_checked;

    // memory bus activity
    int    bus_rd_total;
    int    bus_wr_total;
    addr_t wb_addrs [$];

    // results of the last request
    int bus_reads;
    int bus_writes;
    int ack_edge;

    // random stimulus
    integer seed;
    word_t  rnd_adr;
    word_t  rnd_ctl;
    word_t  rnd_data;
    be_t    rnd_sel;

    //////////////////////////////////////////////////
    // DUT and memory
    //////////////////////////////////////////////////

    cache_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_adr(cpu_adr),
        .cpu_sel(cpu_sel), .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_sel(mem_sel), .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    tb_mem_model #(
        .DEPTH_WIDTH(MEM_WORDS_LOG2),
        .FILL_XOR   (FILL_XOR)
    ) i_mem_model (
        .clk(clk), .rst_n(rst_n), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
        .adr(mem_adr), .sel(mem_sel), .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic word_t preload_word(input int unsigned word_adr);
        return word_t'(word_adr) ^ FILL_XOR;
    endfunction

    // byte lanes with sel set come from the new word
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input be_t sel);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic word_t expected_read(input addr_t adr);
        return shadow[adr[2 +: MEM_WORDS_LOG2]];
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic compare_value(input string name, input word_t expected,
                                 input word_t actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    task automatic idle_outputs_low(input string name);
        assert (cpu_ack === 1'b0 && mem_cyc === 1'b0) else begin
            $display("ERROR %s: expected cpu_ack=0 mem_cyc=0, actual cpu_ack=%b mem_cyc=%b",
                     name, cpu_ack, mem_cyc);
            $display("Simulation failed");
            $fatal(1, "bus active without a request");
        end
    endtask

    task automatic expect_bus_cycles(input string name, input int rd, input int wr);
        compare_value({name, " mem reads"}, rd, bus_reads);
        compare_value({name, " mem writes"}, wr, bus_writes);
    endtask

    // a hit touches no memory and acks at a fixed edge
    task automatic hit_without_memory(input string name);
        expect_bus_cycles(name, 0, 0);
        compare_value({name, " ack edge"}, HIT_ACK_EDGE, ack_edge);
    endtask

    // read data checked on every read ack
    always @(posedge clk) begin
        if (cpu_ack === 1'b1 && chk_read) begin
            assert (cpu_dat_r === exp_data) else report_mismatch(chk_name, exp_data, cpu_dat_r);
            reads_checked++;
        end
    end

    // completed memory cycles and write-back addresses
    always @(posedge clk) begin
        if (rst_n) begin
            // stb travels with cyc for every word
            compare_value("mem_stb", mem_cyc, mem_stb);
        end
        if (rst_n && mem_cyc && mem_stb && mem_ack) begin
            if (mem_we) begin
                // write-back words carry all byte lanes
                compare_value("wb_sel", 32'hf, mem_sel);
                bus_wr_total++;
                wb_addrs.push_back(mem_adr);
            end else begin
                bus_rd_total++;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // one processor request, held until ack
    task automatic cpu_request(input string name, input logic we, input addr_t adr,
                               input be_t sel, input word_t data);
        int rd_start;
        int wr_start;
        int edges;
        @(posedge clk);
        #(DRIVE_DELAY);
        rd_start = bus_rd_total;
        wr_start = bus_wr_total;
        chk_name = name;
        chk_read = !we;
        exp_data = expected_read(adr);
        if (!we) begin
            reads_issued++;
        end
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_sel   = sel;
        cpu_dat_w = data;
        // first edge samples stb
        @(posedge clk);
        edges = 1;
        while (cpu_ack !== 1'b1) begin
            @(posedge clk);
            edges++;
        end
        ack_edge = edges - 1;
        #(DRIVE_DELAY);
        cpu_cyc  = 1'b0;
        cpu_stb  = 1'b0;
        cpu_we   = 1'b0;
        chk_read = 1'b0;
        if (we) begin
            shadow[adr[2 +: MEM_WORDS_LOG2]] = merge_bytes(expected_read(adr), data, sel);
        end
        bus_reads  = bus_rd_total - rd_start;
        bus_writes = bus_wr_total - wr_start;
    endtask

    // run time limit from the request count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, a request never completed");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed          = 32'hb908ee19;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cpu_cyc       = 1'b0;
        cpu_stb       = 1'b0;
        cpu_we        = 1'b0;
        cpu_adr       = '0;
        cpu_sel       = '0;
        cpu_dat_w     = '0;
        chk_read      = 1'b0;
        exp_data      = '0;
        reads_issued  = 0;
        reads_checked = 0;
        bus_rd_total  = 0;
        bus_wr_total  = 0;
        for (int i = 0; i < (1 << MEM_WORDS_LOG2); i++) begin
            shadow[i] = preload_word(i);
        end

        // reset phase, bus stays quiet
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            idle_outputs_low("reset");
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            idle_outputs_low("after_reset");
        end

        // cold misses, one line fetched each
        cpu_request("cold_read_0", 1'b0, 32'h000, 4'hf, '0);
        expect_bus_cycles("cold_read_0", 4, 0);
        cpu_request("cold_read_1", 1'b0, 32'h014, 4'hf, '0);
        expect_bus_cycles("cold_read_1", 4, 0);
        cpu_request("cold_read_2", 1'b0, 32'h128, 4'hf, '0);
        expect_bus_cycles("cold_read_2", 4, 0);

        // hits on a resident line
        cpu_request("read_hit", 1'b0, 32'h000, 4'hf, '0);
        hit_without_memory("read_hit");
        cpu_request("write_hit", 1'b1, 32'h004, 4'b0110, 32'hc0de_1234);
        hit_without_memory("write_hit");
        cpu_request("read_merged", 1'b0, 32'h004, 4'hf, '0);
        hit_without_memory("read_merged");

        // write allocate
        cpu_request("write_miss", 1'b1, 32'h230, 4'b1001, 32'hab00_00cd);
        expect_bus_cycles("write_miss", 4, 0);
        cpu_request("read_alloc", 1'b0, 32'h230, 4'hf, '0);
        hit_without_memory("read_alloc");

        ////////////////////////////////////////////////// 
        // three tags in set 5, both ways dirty first
        cpu_request("fill_way_a", 1'b1, 32'h054, 4'b0011, 32'h1357_9bdf);
        expect_bus_cycles("fill_way_a", 4, 0);
        cpu_request("fill_way_b", 1'b1, 32'h158, 4'hf, 32'h2468_ace0);
        expect_bus_cycles("fill_way_b", 4, 0);
        // read of the 0x050 line leaves lru on the line at 0x150
        cpu_request("touch_way_a", 1'b0, 32'h054, 4'hf, '0);
        hit_without_memory("touch_way_a");
        wb_addrs.delete();
        cpu_request("evict_dirty", 1'b0, 32'h250, 4'hf, '0);
        expect_bus_cycles("evict_dirty", 4, 4);
        for (int i = 0; i < 4; i++) begin
            compare_value("evict_wb_addr", 32'h150 + 4 * i, wb_addrs[i]);
        end
        // evicted write must come back from memory
        cpu_request("reread_evicted", 1'b0, 32'h158, 4'hf, '0);
        expect_bus_cycles("reread_evicted", 4, 0);

        // random mix over four tags per set
        for (int n = 0; n < RANDOM_REQS; n++) begin
            rnd_adr  = $random(seed) & 32'h0000_03fc;
            rnd_ctl  = $random(seed);
            rnd_data = $random(seed);
            rnd_sel  = rnd_ctl[3:0];
            if (rnd_sel == '0) begin
                rnd_sel = 4'hf;
            end
            cpu_request("random_mix", rnd_ctl[4], rnd_adr, rnd_sel, rnd_data);
        end

        @(posedge clk);
        if (reads_checked == reads_issued) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("ERROR read_count: expected %0d, actual %0d", reads_issued,
                     reads_checked);
            $display("Simulation failed");
            $fatal(1, "missing read checks");
        end
    end

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter int               DEPTH_WIDTH = 10,
    parameter cache_pkg::word_t FILL_XOR = 32'h0
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             cyc,
    input  wire logic             stb,
    input  wire logic             we,
    input  wire cache_pkg::addr_t adr,
    input  wire cache_pkg::be_t   sel,
    input  wire cache_pkg::word_t dat_w,
    output cache_pkg::word_t      dat_r,
    output logic                  ack
);
    import cache_pkg::*;

    localparam int DEPTH = 1 << DEPTH_WIDTH;

    // word storage
    word_t mem [DEPTH];

    // word address, byte offset dropped
    logic [DEPTH_WIDTH-1:0] word_adr;

    // new cycle seen, ack follows one clock later
    logic start;

    assign word_adr = adr[2 +: DEPTH_WIDTH];
    assign start    = rst_n && cyc && stb && !ack;

    //////////////////////////////////////////////////
    // preload
    //////////////////////////////////////////////////

    // every word holds its own word address mixed with a constant
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = word_t'(i) ^ FILL_XOR;
        end
    end

    //////////////////////////////////////////////////
    // wishbone classic slave
    //////////////////////////////////////////////////

    // one wait state, ack high for a single cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc && stb && !ack;
        end
    end

    // data moves on the cycle that raises ack
    always @(posedge clk) begin
        if (start) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        mem[word_adr][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end else begin
                dat_r <= mem[word_adr];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int OFFSET_WIDTH = 2,
    parameter int INDEX_WIDTH = 4,
    localparam int TAG_WIDTH = cache_pkg::addr_width - 2 - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    // processor side
    input  wire logic             cpu_cyc,
    input  wire logic             cpu_stb,
    input  wire logic             cpu_we,
    input  wire cache_pkg::addr_t cpu_adr,
    input  wire cache_pkg::be_t   cpu_sel,
    input  wire cache_pkg::word_t cpu_dat_w,
    output cache_pkg::word_t      cpu_dat_r,
    output logic                  cpu_ack,
    // memory side
    output logic                  mem_cyc,
    output logic                  mem_stb,
    output logic                  mem_we,
    output cache_pkg::addr_t      mem_adr,
    output cache_pkg::be_t        mem_sel,
    output cache_pkg::word_t      mem_dat_w,
    input  wire cache_pkg::word_t mem_dat_r,
    input  wire logic             mem_ack
);
    import cache_pkg::*;

    // controller to way set
    logic                    enable, cmp, write;
    logic                    mark_dirty, set_valid;
    be_t                     byte_en;
    word_t                   wdata;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] word_sel;
    logic [TAG_WIDTH-1:0]    tag;

    // way set back to controller
    logic                    hit, victim_dirty;
    logic [TAG_WIDTH-1:0]    victim_tag;
    word_t                   rdata;

    cache_ctrl #(
        .OFFSET_WIDTH(OFFSET_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_cache_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_adr(cpu_adr),
        .cpu_sel(cpu_sel), .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_sel(mem_sel), .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack),
        .enable(enable), .cmp(cmp), .write(write), .byte_en(byte_en), .wdata(wdata),
        .mark_dirty(mark_dirty), .set_valid(set_valid), .index(index),
        .word_sel(word_sel), .tag(tag),
        .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag), .rdata(rdata)
    );

    cache_2ways #(
        .OFFSET_WIDTH(OFFSET_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_cache_2ways (
        .clk(clk), .rst_n(rst_n),
        .enable(enable), .cmp(cmp), .write(write), .byte_en(byte_en),
        .mark_dirty(mark_dirty), .set_valid(set_valid), .index(index),
        .word_sel(word_sel), .tag_in(tag), .data_in(wdata),
        .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag), .data_out(rdata)
    );

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int OFFSET_WIDTH = 2,
    parameter int INDEX_WIDTH = 4,
    localparam int TAG_WIDTH = cache_pkg::addr_width - 2 - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // processor port, wishbone slave
    input  wire logic                    cpu_cyc,
    input  wire logic                    cpu_stb,
    input  wire logic                    cpu_we,
    input  wire cache_pkg::addr_t        cpu_adr,
    input  wire cache_pkg::be_t          cpu_sel,
    input  wire cache_pkg::word_t        cpu_dat_w,
    output cache_pkg::word_t             cpu_dat_r,
    output logic                         cpu_ack,
    // memory port, wishbone master
    output logic                         mem_cyc,
    output logic                         mem_stb,
    output logic                         mem_we,
    output cache_pkg::addr_t             mem_adr,
    output cache_pkg::be_t               mem_sel,
    output cache_pkg::word_t             mem_dat_w,
    input  wire cache_pkg::word_t        mem_dat_r,
    input  wire logic                    mem_ack,
    // way set control
    output logic                         enable,
    output logic                         cmp,
    output logic                         write,
    output cache_pkg::be_t               byte_en,
    output cache_pkg::word_t             wdata,
    output logic                         mark_dirty,
    output logic                         set_valid,
    output logic [INDEX_WIDTH-1:0]       index,
    output logic [OFFSET_WIDTH-1:0]      word_sel,
    output logic [TAG_WIDTH-1:0]         tag,
    // way set results
    input  wire logic                    hit,
    input  wire logic                    victim_dirty,
    input  wire logic [TAG_WIDTH-1:0]    victim_tag,
    input  wire cache_pkg::word_t        rdata
);
    import cache_pkg::*;

    ctrl_state_t state;

    // word within the line being moved
    logic [OFFSET_WIDTH-1:0] cnt;

    // cpu word access against the ways
    logic access;

    // ack on a compare hit, first pass or replay
    logic done;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    // tag | index | word | byte
    assign tag   = cpu_adr[addr_width-1 -: TAG_WIDTH];
    assign index = cpu_adr[OFFSET_WIDTH+2 +: INDEX_WIDTH];

    assign access = (state == lookup) || (state == finish);
    assign done   = access && hit;

    // cpu word on compare, counter while moving a line
    assign word_sel = access ? cpu_adr[2 +: OFFSET_WIDTH] : cnt;

    //////////////////////////////////////////////////
    // request sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            cnt     <= '0;
            cpu_ack <= 1'b0;
        end else begin
            cpu_ack <= 1'b0;
            case (state)
                idle: begin
                    // stb is still up in the ack cycle
                    if (cpu_cyc && cpu_stb && !cpu_ack) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    cnt <= '0;
                    if (hit) begin
                        cpu_ack <= 1'b1;
                        state   <= idle;
                    end else if (victim_dirty) begin
                        state <= wb_word;
                    end else begin
                        state <= refill_word;
                    end
                end
                wb_word: begin
                    // counter wraps to zero for the refill
                    if (mem_ack) begin
                        cnt <= cnt + 1'b1;
                        if (&cnt) begin
                            state <= refill_word;
                        end
                    end
                end
                refill_word: begin
                    if (mem_ack) begin
                        cnt <= cnt + 1'b1;
                        if (&cnt) begin
                            state <= finish;
                        end
                    end
                end
                finish: begin
                    // replay hits the new line
                    cpu_ack <= 1'b1;
                    state   <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // read data held through the ack cycle
    always_ff @(posedge clk) begin
        if (done) begin
            cpu_dat_r <= rdata;
        end
    end

    //////////////////////////////////////////////////
    // way set control
    //////////////////////////////////////////////////

    assign enable = (state != idle);
    assign cmp    = access;

    // cpu store on compare, memory word on each refill ack
    assign write      = access ? cpu_we : ((state == refill_word) && mem_ack);
    assign byte_en    = access ? cpu_sel : '1;
    assign wdata      = access ? cpu_dat_w : mem_dat_r;
    assign mark_dirty = access && cpu_we;
    assign set_valid  = (state == refill_word);

    //////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////

    // cyc and stb held across the words of a line
    assign mem_cyc   = (state == wb_word) || (state == refill_word);
    assign mem_stb   = mem_cyc;
    assign mem_we    = (state == wb_word);
    assign mem_sel   = '1;
    assign mem_dat_w = rdata;

    // old line address out, new line address in
    assign mem_adr = {(mem_we ? victim_tag : tag), index, cnt, 2'b00};

endmodule

`default_nettype wire

// File: hdl/cache_2ways.sv
`timescale 1ns/1ps
`default_nettype none

module cache_2ways #(
    parameter int OFFSET_WIDTH = 2,
    parameter int INDEX_WIDTH = 4,
    localparam int TAG_WIDTH = cache_pkg::addr_width - 2 - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    enable,
    input  wire logic                    cmp,
    input  wire logic                    write,
    input  wire cache_pkg::be_t          byte_en,
    input  wire logic                    mark_dirty,
    input  wire logic                    set_valid,
    input  wire logic [INDEX_WIDTH-1:0]  index,
    input  wire logic [OFFSET_WIDTH-1:0] word_sel,
    input  wire logic [TAG_WIDTH-1:0]    tag_in,
    input  wire cache_pkg::word_t        data_in,
    output logic                         hit,
    output logic                         victim_dirty,
    output logic [TAG_WIDTH-1:0]         victim_tag,
    output cache_pkg::word_t             data_out
);
    import cache_pkg::*;

    // per way results
    logic                 hit0, hit1;
    logic                 valid0, valid1;
    logic                 dirty0, dirty1;
    logic [TAG_WIDTH-1:0] tag0, tag1;
    word_t                data0, data1;

    // replacement
    logic victim;
    logic victim_ff;
    logic sel_way;

    // way enables
    logic en0, en1;

    //////////////////////////////////////////////////
    // victim choice
    //////////////////////////////////////////////////

    victim_select #(
        .INDEX_WIDTH(INDEX_WIDTH)
    ) i_victim_select (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .valid0   (valid0),
        .valid1   (valid1),
        .dirty0   (dirty0),
        .dirty1   (dirty1),
        .touch    (enable && cmp && hit),
        .touch_way(hit1),
        .victim   (victim)
    );

    // held from the compare access so every
    // write-back and refill word lands in one way
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_ff <= 1'b0;
        end else if (enable && cmp) begin
            victim_ff <= victim;
        end
    end

    // live choice during compare, frozen one for line moves
    assign sel_way = cmp ? victim : victim_ff;

    // compare reaches both ways, a line move only the victim
    assign en0 = enable && (cmp || !victim_ff);
    assign en1 = enable && (cmp || victim_ff);

    //////////////////////////////////////////////////
    // the two ways
    //////////////////////////////////////////////////

    cache_way #(
        .OFFSET_WIDTH(OFFSET_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_way0 (
        .clk(clk), .rst_n(rst_n), .enable(en0), .cmp(cmp), .write(write),
        .byte_en(byte_en), .mark_dirty(mark_dirty), .set_valid(set_valid),
        .index(index), .word_sel(word_sel), .tag_in(tag_in), .data_in(data_in),
        .hit(hit0), .valid(valid0), .dirty(dirty0), .tag_out(tag0), .data_out(data0)
    );

    cache_way #(
        .OFFSET_WIDTH(OFFSET_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_way1 (
        .clk(clk), .rst_n(rst_n), .enable(en1), .cmp(cmp), .write(write),
        .byte_en(byte_en), .mark_dirty(mark_dirty), .set_valid(set_valid),
        .index(index), .word_sel(word_sel), .tag_in(tag_in), .data_in(data_in),
        .hit(hit1), .valid(valid1), .dirty(dirty1), .tag_out(tag1), .data_out(data1)
    );

    //////////////////////////////////////////////////
    // result muxing
    //////////////////////////////////////////////////

    assign hit = hit0 || hit1;

    // write-back source, tag gives the old line address
    assign victim_dirty = sel_way ? dirty1 : dirty0;
    assign victim_tag   = sel_way ? tag1 : tag0;

    // hit way on compare, victim way while moving a line
    assign data_out = cmp ? (hit1 ? data1 : data0) : (victim_ff ? data1 : data0);

endmodule

`default_nettype wire

// File: hdl/victim_select.sv
`timescale 1ns/1ps
`default_nettype none

module victim_select #(
    parameter int INDEX_WIDTH = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [INDEX_WIDTH-1:0] index,
    input  wire logic                   valid0,
    input  wire logic                   valid1,
    input  wire logic                   dirty0,
    input  wire logic                   dirty1,
    input  wire logic                   touch,
    input  wire logic                   touch_way,
    output logic                        victim
);
    localparam int SETS = 1 << INDEX_WIDTH;

    // one bit per set, names the least recently used way
    logic [SETS-1:0] lru;

    // replacement priority
    always_comb begin
        if (!valid0) begin
            // empty way 0 first
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else if (dirty0 != dirty1) begin
            // the clean one, skips a write-back
            victim = dirty0;
        end else begin
            victim = lru[index];
        end
    end

    // used way becomes most recent, other one is next out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (touch) begin
            lru[index] <= ~touch_way;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter int OFFSET_WIDTH = 2,
    parameter int INDEX_WIDTH = 4,
    localparam int TAG_WIDTH = cache_pkg::addr_width - 2 - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    enable,
    input  wire logic                    cmp,
    input  wire logic                    write,
    input  wire cache_pkg::be_t          byte_en,
    input  wire logic                    mark_dirty,
    input  wire logic                    set_valid,
    input  wire logic [INDEX_WIDTH-1:0]  index,
    input  wire logic [OFFSET_WIDTH-1:0] word_sel,
    input  wire logic [TAG_WIDTH-1:0]    tag_in,
    input  wire cache_pkg::word_t        data_in,
    output logic                         hit,
    output logic                         valid,
    output logic                         dirty,
    output logic [TAG_WIDTH-1:0]         tag_out,
    output cache_pkg::word_t             data_out
);
    import cache_pkg::*;

    localparam int SETS = 1 << INDEX_WIDTH;
    localparam int WORDS = SETS << OFFSET_WIDTH;

    // per set state bits
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    // per set tags and the line words
    logic [TAG_WIDTH-1:0] tag_mem [SETS];
    word_t                data_mem [WORDS];

    // compare access writes only on a hit, fill access writes blind
    logic wr_en;

    //////////////////////////////////////////////////
    // combinational read side
    //////////////////////////////////////////////////

    assign valid    = valid_q[index];
    assign dirty    = dirty_q[index];
    assign tag_out  = tag_mem[index];
    assign data_out = data_mem[{index, word_sel}];

    // hit needs a valid line and a matching tag
    assign hit = valid && (tag_out == tag_in);

    assign wr_en = enable && write && (hit || !cmp);

    //////////////////////////////////////////////////
    // update
    //////////////////////////////////////////////////

    // valid and dirty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            if (set_valid) begin
                // refill word, line arrives clean
                valid_q[index] <= 1'b1;
                dirty_q[index] <= 1'b0;
            end else if (mark_dirty) begin
                // cpu store into a resident line
                dirty_q[index] <= 1'b1;
            end
        end
    end

    // tag and data words
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (set_valid) begin
                tag_mem[index] <= tag_in;
            end
            // byte lanes one at a time
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    data_mem[{index, word_sel}][8*b +: 8] <= data_in[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////

    // byte address width on both wishbone ports
    localparam int addr_width = 32;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    // one data word, cpu and memory side alike
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [addr_width-1:0] addr_t;

    // one select bit per byte lane
    typedef logic [3:0] be_t;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////

    // idle        waiting for a cpu request
    // lookup      tag compare in both ways
    // wb_word     dirty victim out, one word per bus cycle
    // refill_word line in from memory, one word per bus cycle
    // finish      replay of the request against the new line
    typedef enum logic [2:0] {
        idle,
        lookup,
        wb_word,
        refill_word,
        finish
    } ctrl_state_t;

endpackage

`default_nettype wire
